// ==== verification/parking_trace.txt ====
# op value rejected fee, value and fee in hex
# value is the plate for entry and exit, the tick count for ticks
entry 1002 0 00
entry 1101 0 00
entry 9003 0 00
entry 9004 0 00
entry 8006 0 00
entry 8105 0 00
ticks 0a 0 00
exit 9003 0 00
exit 8006 0 0a
exit 1101 0 14
exit 1234 1 00
entry 1002 1 00
entry 0000 1 00
exit 0000 1 00
entry 100a 0 00
entry 100c 0 00
entry 100e 0 00
entry 1010 0 00
entry 1012 0 00
ticks 82 0 00
exit 1002 0 ff
exit 8105 0 8c
exit 9004 0 00
entry 1121 0 00
entry 1123 0 00
entry 1125 0 00
entry 1127 0 00
entry 1129 0 00
entry 112b 0 00
entry 112d 1 00
exit 1121 0 00
entry 112d 0 00

// ==== tb.f ====
hdl/park_cfg_pkg.sv
hdl/park_types_pkg.sv
hdl/bank_if.sv
hdl/fee_meter.sv
hdl/slot_bank.sv
hdl/slot_allocator.sv
hdl/elevator_ctrl.sv
hdl/parking_top.sv
verification/parking_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := parking_tb
FILELIST   := tb.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/parking_tb.sv ====
`timescale 1ns/1ns

module parking_tb;

    localparam int bay_count  = 14;
    localparam int wait_limit = 2000;                      // cycles per wait

    logic        clock;
    logic        reset;
    logic        cmd_valid;
    logic        cmd_exit;
    logic [15:0] license_plate;
    logic        tick;
    logic        cmd_ready;
    logic        done;
    logic        rejected;
    logic [7:0]  fee;
    logic [2:0]  current_floor;
    logic [15:0] moving;
    logic [3:0]  empty_suv;
    logic [3:0]  empty_sedan;
    logic        full_suv;
    logic        full_sedan;

    logic [15:0] bay_plate [bay_count];                    // reference bays, 0 is free
    int          value_errors;
    int          other_errors;
    logic        stop;                                     // set on a timeout

    parking_top u_parking_top (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // free bays on odd floors (suv) or even floors (sedan), reserved left bays excluded
    function automatic int free_count(input logic suv_side);
        int n;
        n = 0;
        for (int i = 0; i < bay_count; i++) begin
            if (bay_plate[i] == 0 && !(i < 4 && i % 2 == 0)
                    && (((i / 2) % 2 == 0) == suv_side)) begin
                n++;
            end
        end
        return n;
    endfunction

    // lowest floor first, left before right
    function automatic int find_free(input logic [15:0] plate);
        logic sedan_full;
        sedan_full = (free_count(1'b0) == 0);
        for (int i = 0; i < bay_count; i++) begin
            if (bay_plate[i] != 0) continue;
            if ((i / 2) % 2 == 0 ? !(plate[0] || sedan_full) : plate[0]) continue;  // parity
            if (i < 4 && i % 2 == 0 && plate[15:12] != 4'd9) continue;  // disabled only
            return i;
        end
        return -1;
    endfunction

    function automatic int find_plate(input logic [15:0] plate);
        for (int i = 0; i < bay_count; i++) begin
            if (plate != 0 && bay_plate[i] == plate) return i;
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h got %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR %s", what);
        other_errors++;
    endtask

    task automatic check_occupancy();
        check_value("empty_suv", 16'(free_count(1'b1)), 16'(empty_suv));
        check_value("empty_sedan", 16'(free_count(1'b0)), 16'(empty_sedan));
        check_value("full_suv", 16'(free_count(1'b1) == 0), 16'(full_suv));
        check_value("full_sedan", 16'(free_count(1'b0) == 0), 16'(full_sedan));
    endtask

    task automatic apply_ticks(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clock);
            tick <= 1'b1;
        end
        @(posedge clock);
        tick <= 1'b0;
    endtask

    task automatic run_cmd(input logic is_exit, input logic [15:0] plate,
                           input logic exp_rej, input logic [7:0] exp_fee);
        int         bay;
        int         cycles;
        logic [2:0] peak;
        logic       carried;
        if (plate == 0) begin
            bay = -1;
        end else if (is_exit) begin
            bay = find_plate(plate);
        end else begin
            bay = (find_plate(plate) >= 0) ? -1 : find_free(plate);  // duplicate is rejected
        end
        assert ((bay < 0) == exp_rej) else
            report_problem($sformatf("trace and model disagree on rejecting plate %h", plate));
        @(posedge clock);
        cmd_valid     <= 1'b1;
        cmd_exit      <= is_exit;
        license_plate <= plate;
        cycles = 0;
        @(negedge clock);
        while (!cmd_ready && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!cmd_ready) begin
            report_problem($sformatf("cmd_ready stayed low for plate %h", plate));
            stop = 1'b1;
            cmd_valid <= 1'b0;
            return;
        end
        @(posedge clock);                                  // accepted here
        cmd_valid     <= 1'b0;
        license_plate <= 16'h0;
        peak    = '0;
        carried = 1'b0;
        cycles  = 0;
        @(negedge clock);
        while (!done && cycles < wait_limit) begin
            assert (!cmd_ready) else report_problem("cmd_ready high while a job runs");
            assert (moving == 0 || (bay >= 0 && moving == plate)) else
                report_problem("moving shows a wrong plate");
            if (moving != 0) carried = 1'b1;
            if (current_floor > peak) peak = current_floor;
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            report_problem($sformatf("no done for plate %h within %0d cycles", plate, wait_limit));
            stop = 1'b1;
            return;
        end
        check_value("rejected", 16'(exp_rej), 16'(rejected));
        check_value("fee", 16'(exp_fee), 16'(fee));
        check_value("current_floor", 16'h0, 16'(current_floor));
        check_value("moving", 16'h0, moving);
        check_value("cmd_ready", 16'h0, 16'(cmd_ready));
        check_value("current_floor peak", 16'(bay < 0 ? 0 : bay / 2 + 1), 16'(peak));
        assert (carried == (bay >= 0)) else
            report_problem($sformatf("moving did not carry plate %h as expected", plate));
        if (bay >= 0) bay_plate[bay] = is_exit ? 16'h0 : plate;
        check_occupancy();
    endtask

    initial begin
        logic [8*8-1:0]   op;
        logic [8*160-1:0] rest;
        logic [15:0]      value;
        logic [7:0]       exp_fee;
        int               exp_rej;
        int               fd;
        int               code;
        int               gap;
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_exit      = 1'b0;
        license_plate = 16'h0;
        tick          = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        stop          = 1'b0;
        for (int i = 0; i < bay_count; i++) begin
            bay_plate[i] = 16'h0;
        end
        void'($urandom(1778));
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("cmd_ready", 16'h1, 16'(cmd_ready));   // state out of reset
        check_value("done", 16'h0, 16'(done));
        check_value("rejected", 16'h0, 16'(rejected));
        check_value("fee", 16'h0, 16'(fee));
        check_value("current_floor", 16'h0, 16'(current_floor));
        check_value("moving", 16'h0, moving);
        check_occupancy();

        fd = $fopen("verification/parking_trace.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open verification/parking_trace.txt");
            stop = 1'b1;
        end
        while (!stop) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) break;
            if (op == "#") begin
                code = $fgets(rest, fd);                   // comment line
                continue;
            end
            code = $fscanf(fd, "%h %d %h", value, exp_rej, exp_fee);
            if (code != 3) begin
                report_problem("trace line is malformed");
                break;
            end
            gap = int'($urandom % 4);
            repeat (gap) @(posedge clock);
            if (op == "entry") begin
                run_cmd(1'b0, value, exp_rej != 0, exp_fee);
            end else if (op == "exit") begin
                run_cmd(1'b1, value, exp_rej != 0, exp_fee);
            end else if (op == "ticks") begin
                apply_ticks(int'(value));
            end else begin
                report_problem("trace holds an unknown operation");
            end
        end
        if (fd != 0) $fclose(fd);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hdl/parking_top.sv ====
`timescale 1ns/1ns

module parking_top import park_types_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   cmd_valid,
    input  logic   cmd_exit,
    input  plate_t license_plate,
    input  logic   tick,
    output logic   cmd_ready,
    output logic   done,
    output logic   rejected,
    output fee_t   fee,
    output floor_t current_floor,
    output plate_t moving,
    output count_t empty_suv,
    output count_t empty_sedan,
    output logic   full_suv,
    output logic   full_sedan
);

    bank_if bank_bus ();

    logic     free_found;
    logic     match_found;
    bay_idx_t free_bay;
    bay_idx_t match_bay;

    assign full_sedan = bank_bus.full_sedan;

    slot_bank u_slot_bank (
        .clock       (clock),
        .reset       (reset),
        .tick        (tick),
        .bus         (bank_bus.bank),
        .empty_suv   (empty_suv),
        .empty_sedan (empty_sedan),
        .full_suv    (full_suv)
    );

    slot_allocator u_slot_allocator (
        .plate       (bank_bus.plate_in),                 // latched command plate
        .occupied    (bank_bus.occupied),
        .plates      (bank_bus.plates),
        .full_sedan  (bank_bus.full_sedan),
        .free_found  (free_found),
        .match_found (match_found),
        .free_bay    (free_bay),
        .match_bay   (match_bay)
    );

    elevator_ctrl u_elevator_ctrl (
        .clock         (clock),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_exit      (cmd_exit),
        .license_plate (license_plate),
        .cmd_ready     (cmd_ready),
        .done          (done),
        .rejected      (rejected),
        .fee           (fee),
        .current_floor (current_floor),
        .moving        (moving),
        .bus           (bank_bus.ctrl),
        .free_found    (free_found),
        .match_found   (match_found),
        .free_bay      (free_bay),
        .match_bay     (match_bay)
    );

endmodule

// ==== hdl/elevator_ctrl.sv ====
`timescale 1ns/1ns

module elevator_ctrl import park_types_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     cmd_valid,
    input  logic     cmd_exit,
    input  plate_t   license_plate,
    output logic     cmd_ready,
    output logic     done,
    output logic     rejected,
    output fee_t     fee,
    output floor_t   current_floor,
    output plate_t   moving,
    bank_if.ctrl     bus,
    input  logic     free_found,
    input  logic     match_found,
    input  bay_idx_t free_bay,
    input  bay_idx_t match_bay
);

    elev_state_t state;
    plate_t      plate_q;
    logic        exit_q;
    bay_idx_t    bay_q;
    logic        rejected_q;
    fee_t        fee_q;

    logic        accept;
    logic        first_step;
    logic        job_reject;
    bay_idx_t    job_bay;
    floor_t      job_floor;
    floor_t      floor_up;

    assign cmd_ready  = (state == st_idle);
    assign accept     = cmd_valid && cmd_ready;
    assign first_step = (state == st_lift_up) && (current_floor == '0);  // decision cycle

    assign job_reject = (plate_q == '0)
        || (exit_q ? !match_found : (!free_found || match_found));
    assign job_bay    = first_step ? (exit_q ? match_bay : free_bay) : bay_q;
    assign job_floor  = job_bay[3:1] + 1'b1;
    assign floor_up   = current_floor + 1'b1;

    always_ff @(posedge clock) begin
        if (accept) begin
            plate_q <= license_plate;
            exit_q  <= cmd_exit;
        end
        if (first_step) begin
            bay_q <= job_bay;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= st_idle;
            current_floor <= '0;
            moving        <= '0;
            rejected_q    <= 1'b0;
            fee_q         <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        rejected_q <= 1'b0;
                        fee_q      <= '0;
                        state      <= st_lift_up;
                    end
                end
                st_lift_up: begin
                    if (first_step && job_reject) begin
                        rejected_q <= 1'b1;
                        state      <= st_finish;  // car never leaves the entrance
                    end else begin
                        if (first_step && !exit_q) begin
                            moving <= plate_q;    // entering car rides up
                        end
                        current_floor <= floor_up;
                        if (floor_up == job_floor) begin
                            state <= st_transfer;
                        end
                    end
                end
                st_transfer: begin
                    fee_q  <= exit_q ? bus.bay_fee : '0;
                    moving <= exit_q ? plate_q : '0;
                    state  <= st_lift_down;
                end
                st_lift_down: begin
                    current_floor <= current_floor - 1'b1;
                    if (current_floor == floor_t'(1)) begin
                        moving <= '0;             // car handed out at floor 0
                        state  <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign bus.store    = (state == st_transfer) && !exit_q;
    assign bus.clear    = (state == st_transfer) && exit_q;
    assign bus.bay      = bay_q;
    assign bus.plate_in = plate_q;

    assign done     = (state == st_finish);
    assign rejected = done && rejected_q;
    assign fee      = done ? fee_q : '0;

    a_floor_step: assert property (@(posedge clock) disable iff (reset)
        (4'(current_floor) - 4'($past(current_floor))) inside {4'd0, 4'd1, 4'hf});

    a_done_pulse: assert property (@(posedge clock) disable iff (reset)
        done |=> !done);

endmodule

// ==== hdl/slot_allocator.sv ====
`timescale 1ns/1ns

module slot_allocator import park_cfg_pkg::*, park_types_pkg::*; (
    input  plate_t    plate,
    input  bay_mask_t occupied,
    input  plate_t    plates [num_bays],
    input  logic      full_sedan,
    output logic      free_found,
    output logic      match_found,
    output bay_idx_t  free_bay,
    output bay_idx_t  match_bay
);

    logic      is_suv;
    logic      is_disabled;
    bay_mask_t allowed;
    bay_mask_t match;

    always_comb begin
        int  f;
        logic left;
        is_suv      = plate[body_bit];
        is_disabled = (plate[class_msb:class_lsb] == class_disabled);
        for (int i = 0; i < num_bays; i++) begin
            f    = i / 2 + 1;
            left = (i % 2 == 0);
            allowed[i] = !occupied[i]
                && ((f % 2 == 1) ? (is_suv || full_sedan) : !is_suv)   // parity rule
                && !(reserved_floors[f] && left && !is_disabled);
            match[i] = occupied[i] && (plates[i] == plate);
        end
    end

    // bay index order is already floor first then left before right
    always_comb begin
        free_found  = 1'b0;
        free_bay    = '0;
        match_found = 1'b0;
        match_bay   = '0;
        for (int i = num_bays - 1; i >= 0; i--) begin  // lowest index wins
            if (allowed[i]) begin
                free_found = 1'b1;
                free_bay   = bay_idx_t'(i);
            end
            if (match[i]) begin
                match_found = 1'b1;
                match_bay   = bay_idx_t'(i);
            end
        end
    end

endmodule

// ==== hdl/slot_bank.sv ====
`timescale 1ns/1ns

module slot_bank import park_cfg_pkg::*, park_types_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   tick,
    bank_if.bank   bus,
    output count_t empty_suv,
    output count_t empty_sedan,
    output logic   full_suv
);

    bay_mask_t occupied_q;
    plate_t    plate_q [num_bays];
    fee_t      meter_fee [num_bays];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            occupied_q <= '0;
        end else begin
            if (bus.store) begin
                occupied_q[bus.bay] <= 1'b1;
            end
            if (bus.clear) begin
                occupied_q[bus.bay] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.store) begin
            plate_q[bus.bay] <= bus.plate_in;
        end
    end

    for (genvar i = 0; i < num_bays; i++) begin : g_meter
        fee_meter u_fee_meter (
            .clock    (clock),
            .reset    (reset),
            .start    (bus.store && (bus.bay == bay_idx_t'(i))),
            .tick     (tick),
            .occupied (occupied_q[i]),
            .plate    (plate_q[i]),
            .fee      (meter_fee[i])
        );
    end

    // reserved left bays are left out of both counts
    always_comb begin
        int f;
        empty_suv   = '0;
        empty_sedan = '0;
        for (int i = 0; i < num_bays; i++) begin
            f = i / 2 + 1;
            if (!occupied_q[i] && !(reserved_floors[f] && (i % 2 == 0))) begin
                if (f % 2 == 1) begin
                    empty_suv = empty_suv + count_t'(1);   // odd floors
                end else begin
                    empty_sedan = empty_sedan + count_t'(1);
                end
            end
        end
    end

    assign full_suv       = (empty_suv == '0);
    assign bus.full_sedan = (empty_sedan == '0);
    assign bus.occupied   = occupied_q;
    assign bus.plates     = plate_q;
    assign bus.bay_fee    = meter_fee[bus.bay];

    // the allocator decision has to agree with the bay state at transfer time
    a_store_free: assert property (@(posedge clock) disable iff (reset)
        bus.store |-> !occupied_q[bus.bay]);

    a_clear_used: assert property (@(posedge clock) disable iff (reset)
        bus.clear |-> occupied_q[bus.bay]);

endmodule

// ==== hdl/fee_meter.sv ====
`timescale 1ns/1ns

module fee_meter import park_cfg_pkg::*, park_types_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   start,
    input  logic   tick,
    input  logic   occupied,
    input  plate_t plate,
    output fee_t   fee
);

    fee_t               rate;
    logic [fee_width:0] sum;                               // one spare bit for overflow

    always_comb begin
        if (plate[class_msb:class_lsb] == class_disabled) begin
            rate = fee_t'(rate_disabled);
        end else if (plate[class_msb:class_lsb] == class_hybrid) begin
            rate = fee_t'(rate_hybrid);
        end else begin
            rate = fee_t'(rate_normal);
        end
        sum = {1'b0, fee} + {1'b0, rate};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fee <= '0;
        end else if (start) begin
            fee <= '0;                                     // new car in this bay
        end else if (tick && occupied) begin
            fee <= (sum > {1'b0, fee_t'(fee_max)}) ? fee_t'(fee_max) : sum[fee_width-1:0];
        end
    end

endmodule

// ==== hdl/bank_if.sv ====
`timescale 1ns/1ns

interface bank_if import park_cfg_pkg::*, park_types_pkg::*; ();

    logic      store;                                      // park plate_in in bay
    logic      clear;                                      // empty bay
    bay_idx_t  bay;
    plate_t    plate_in;

    bay_mask_t occupied;
    plate_t    plates [num_bays];
    fee_t      bay_fee;                                    // meter of the addressed bay
    logic      full_sedan;

    modport ctrl (
        output store, clear, bay, plate_in,
        input  occupied, plates, bay_fee, full_sedan
    );

    modport bank (
        input  store, clear, bay, plate_in,
        output occupied, plates, bay_fee, full_sedan
    );

endinterface

// ==== hdl/park_types_pkg.sv ====
package park_types_pkg;

    import park_cfg_pkg::*;

    typedef logic [plate_width-1:0]   plate_t;             // 0 means no car
    typedef logic [floor_width-1:0]   floor_t;
    typedef logic [bay_idx_width-1:0] bay_idx_t;           // (floor - 1) * 2 + side
    typedef logic [num_bays-1:0]      bay_mask_t;
    typedef logic [fee_width-1:0]     fee_t;
    typedef logic [count_width-1:0]   count_t;

    // elevator job sequence
    typedef enum logic [2:0] {
        st_idle,
        st_lift_up,
        st_transfer,
        st_lift_down,
        st_finish
    } elev_state_t;

endpackage

// ==== hdl/park_cfg_pkg.sv ====
package park_cfg_pkg;

    // tower geometry
    localparam int num_floors    = 8;                      // floor 0 is the entrance
    localparam int num_bays      = 14;                     // left and right on floors 1 to 7
    localparam int floor_width   = $clog2(num_floors);
    localparam int bay_idx_width = $clog2(num_bays);
    localparam int count_width   = $clog2(num_bays + 1);

    // left bays of these floors take disabled cars only
    localparam logic [num_floors-1:0] reserved_floors = 8'b0000_0110;

    // plate fields
    localparam int plate_width = 16;
    localparam int body_bit    = 0;                        // 0 sedan, 1 suv
    localparam int class_msb   = 15;
    localparam int class_lsb   = 12;

    localparam logic [class_msb-class_lsb:0] class_disabled = 4'd9;
    localparam logic [class_msb-class_lsb:0] class_hybrid   = 4'd8;

    // fee per tick for each class
    localparam int fee_width     = 8;
    localparam int rate_disabled = 0;
    localparam int rate_hybrid   = 1;
    localparam int rate_normal   = 2;
    localparam int fee_max       = 255;                    // meters saturate here

endpackage
